//--- verilog/creator_cfg.svh
// Bus widths, address map, version word, reset values and PWM period
`ifndef CREATOR_CFG_SVH
`define CREATOR_CFG_SVH

// --------------------
// Bus geometry
// --------------------
`define CREATOR_ADDR_W 15
`define CREATOR_DATA_W 16
// Top address bits used for slave select
`define CREATOR_REGION_W 3

// Region codes
`define CREATOR_REGION_CTRL 3'b000
`define CREATOR_REGION_GPIO 3'b100

// --------------------
// System control block
// --------------------
// VER0 holds the low word
`define CREATOR_VERSION 64'hBAD2_6032_000A_0001
`define CREATOR_DAC_MUTE_INIT 1'b1
`define CREATOR_DAC_HP_NSPK_INIT 1'b0
`define CREATOR_VOLUME_INIT 15
// Volume bits that reach the PWM
`define CREATOR_VOLUME_W 5
// Clocks per PWM period
`define CREATOR_PWM_PERIOD 30

// GPIO pin count
`define CREATOR_GPIO_W 16

`endif

//--- verilog/creator_bus_pkg.sv
// Bus address, data and region types, region codes and region extraction
`include "creator_cfg.svh"

package creator_bus_pkg;

  // Full word address
  typedef logic [`CREATOR_ADDR_W-1:0] bus_addr_t;

  // One data word
  typedef logic [`CREATOR_DATA_W-1:0] bus_data_t;

  // Decode field at the top of the address
  typedef logic [`CREATOR_REGION_W-1:0] region_t;

  // Regions with a slave behind them
  localparam region_t REGION_CTRL = `CREATOR_REGION_CTRL;
  localparam region_t REGION_GPIO = `CREATOR_REGION_GPIO;

  // Top address bits select the slave
  function automatic region_t region_of(bus_addr_t adr);
    return adr[`CREATOR_ADDR_W-1 -: `CREATOR_REGION_W];
  endfunction

endpackage

//--- verilog/creator_regs_pkg.sv
// Register offset types and field positions for the control and GPIO slaves
package creator_regs_pkg;

  // --------------------
  // System control offsets
  // --------------------
  typedef enum logic [3:0] {
    VER0     = 4'd0,
    VER1     = 4'd1,
    VER2     = 4'd2,
    VER3     = 4'd3,
    DAC_CTRL = 4'd4,
    VOLUME   = 4'd5
  } ctrl_reg_e;

  // DAC_CTRL fields
  localparam int DAC_MUTE_BIT    = 0;
  localparam int DAC_HP_NSPK_BIT = 1;

  // GPIO offsets
  typedef enum logic [1:0] {
    DIR = 2'd0,
    OUT = 2'd1,
    IN  = 2'd2
  } gpio_reg_e;

endpackage

//--- verilog/wb_if.sv
// Bus interface with master, slave and monitor modports
`timescale 1ns/10ps

interface wb_if import creator_bus_pkg::*; ();

  // Request side, owned by the master
  bus_addr_t adr;
  bus_data_t dat_w;
  logic      we;
  logic      cyc;
  logic      stb;

  // Response side, owned by the slave
  bus_data_t dat_r;
  logic      ack;

  modport master (
    output adr, dat_w, we, cyc, stb,
    input  dat_r, ack
  );

  modport slave (
    input  adr, dat_w, we, cyc, stb,
    output dat_r, ack
  );

  // Observe only
  modport monitor (
    input adr, dat_w, dat_r, we, cyc, stb, ack
  );

endinterface

//--- verilog/spi_wb_bridge.sv
// SPI frame receiver with pin synchronizers, bit counter and bus master FSM
`timescale 1ns/10ps

module spi_wb_bridge import creator_bus_pkg::*; (
  input  logic clk,
  input  logic reset_i,
  input  logic sck_i,
  input  logic ss_i,
  input  logic mosi_i,
  output logic miso_o,
  wb_if.master bus
);

  localparam int DATA_W = $bits(bus_data_t);
  localparam int CNT_W  = $clog2(2 * DATA_W + 1);
  // Bit counts at end of command and end of frame
  localparam logic [CNT_W-1:0] CMD_END   = CNT_W'(DATA_W);
  localparam logic [CNT_W-1:0] FRAME_END = CNT_W'(2 * DATA_W);

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_e;

  logic [2:0] sck_sync;
  logic [1:0] ss_sync;
  logic [1:0] mosi_sync;
  logic sck_rise;
  logic sck_fall;
  logic ss_s;
  logic [CNT_W-1:0] bit_cnt;
  logic [CNT_W-1:0] cnt_next;
  bus_data_t in_sr;
  bus_data_t next_word;
  bus_data_t cmd_q;
  bus_data_t wdata_q;
  bus_data_t rd_sr;
  logic cmd_done;
  logic data_done;
  logic start;
  logic shift_out;
  state_e state;

  // --------------------
  // Pin synchronizers
  // --------------------
  // Third sck stage only for edge detect
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sck_sync <= '0;
      ss_sync  <= '1;
    end else begin
      sck_sync <= {sck_sync[1:0], sck_i};
      ss_sync  <= {ss_sync[0], ss_i};
    end
  end

  always_ff @(posedge clk) begin
    mosi_sync <= {mosi_sync[0], mosi_i};
  end

  assign sck_rise  = sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = ~sck_sync[1] & sck_sync[2];
  // High while deselected
  assign ss_s      = ss_sync[1];
  assign cnt_next  = bit_cnt + 1'b1;
  assign next_word = {in_sr[DATA_W-2:0], mosi_sync[1]};

  // --------------------
  // Frame bit counter
  // --------------------
  // Deselect restarts the frame, so a cut frame never reaches 32
  always_ff @(posedge clk) begin
    if (reset_i) begin
      bit_cnt   <= '0;
      cmd_done  <= 1'b0;
      data_done <= 1'b0;
    end else begin
      cmd_done  <= 1'b0;
      data_done <= 1'b0;
      if (ss_s) begin
        bit_cnt <= '0;
      end else if (sck_rise && bit_cnt != FRAME_END) begin
        bit_cnt   <= cnt_next;
        cmd_done  <= (cnt_next == CMD_END);
        data_done <= (cnt_next == FRAME_END);
      end
    end
  end

  // MSB first capture of command and write data
  always_ff @(posedge clk) begin
    if (!ss_s && sck_rise) begin
      in_sr <= next_word;
      if (cnt_next == CMD_END) begin
        cmd_q <= next_word;
      end
      if (cnt_next == FRAME_END) begin
        wdata_q <= next_word;
      end
    end
  end

  // --------------------
  // Bus master
  // --------------------
  // Read after the command word, write after the data word if still selected
  assign start = (cmd_done && !cmd_q[DATA_W-1]) ||
                 (data_done && cmd_q[DATA_W-1] && !ss_s);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state   <= IDLE;
      bus.cyc <= 1'b0;
      bus.stb <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= SETUP;
          end
        end
        SETUP: begin
          bus.cyc <= 1'b1;
          bus.stb <= 1'b1;
          state   <= ACCESS;
        end
        default: begin
          // Drop the request in the cycle after ack
          if (bus.ack) begin
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
            state   <= IDLE;
          end
        end
      endcase
    end
  end

  // Request fields settle one clock ahead of cyc
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      bus.adr   <= bus_addr_t'(cmd_q);
      bus.we    <= cmd_q[DATA_W-1];
      bus.dat_w <= wdata_q;
    end
  end

  // --------------------
  // MISO path
  // --------------------
  // Read word moves out after each falling sck in the data half
  assign shift_out = sck_fall && !ss_s && !cmd_q[DATA_W-1] && (bit_cnt >= CMD_END);

  always_ff @(posedge clk) begin
    if (state == ACCESS && bus.ack && !bus.we) begin
      rd_sr <= bus.dat_r;
    end else if (shift_out) begin
      rd_sr <= {rd_sr[DATA_W-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || ss_s) begin
      miso_o <= 1'b0;
    end else if (shift_out) begin
      miso_o <= rd_sr[DATA_W-1];
    end
  end

  // Strobe only inside a cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset_i)
    $rose(bus.stb) |-> bus.cyc);

  // Address and direction held until the slave answers
  a_req_stable: assert property (@(posedge clk) disable iff (reset_i)
    bus.stb && !bus.ack |=> $stable(bus.adr) && $stable(bus.we));

endmodule

//--- verilog/wb_decoder.sv
// Region decoder with request steering, response mux and default responder
`timescale 1ns/10ps

module wb_decoder import creator_bus_pkg::*; (
  input  logic clk,
  input  logic reset_i,
  wb_if.slave  host,
  wb_if.master ctrl,
  wb_if.master gpio
);

  region_t region;
  logic sel_ctrl;
  logic sel_gpio;
  logic sel_none;
  logic def_ack;

  assign region   = region_of(host.adr);
  assign sel_ctrl = (region == REGION_CTRL);
  assign sel_gpio = (region == REGION_GPIO);
  // Everything else is unmapped
  assign sel_none = !sel_ctrl && !sel_gpio;

  // --------------------
  // Request steering
  // --------------------
  // Address, data and we fan out to both slaves
  assign ctrl.adr   = host.adr;
  assign ctrl.dat_w = host.dat_w;
  assign ctrl.we    = host.we;
  assign gpio.adr   = host.adr;
  assign gpio.dat_w = host.dat_w;
  assign gpio.we    = host.we;

  // Only the selected slave sees the cycle
  assign ctrl.cyc = host.cyc && sel_ctrl;
  assign ctrl.stb = host.stb && sel_ctrl;
  assign gpio.cyc = host.cyc && sel_gpio;
  assign gpio.stb = host.stb && sel_gpio;

  // --------------------
  // Default responder
  // --------------------
  // One clock ack so an unmapped access still completes
  always_ff @(posedge clk) begin
    if (reset_i) begin
      def_ack <= 1'b0;
    end else begin
      def_ack <= host.cyc && host.stb && sel_none && !def_ack;
    end
  end

  // Response mux
  assign host.ack = (sel_ctrl && ctrl.ack) || (sel_gpio && gpio.ack) || def_ack;

  always_comb begin
    if (sel_ctrl) begin
      host.dat_r = ctrl.dat_r;
    end else if (sel_gpio) begin
      host.dat_r = gpio.dat_r;
    end else begin
      // Unmapped reads return zero
      host.dat_r = '0;
    end
  end

  // No slave answers outside a strobe
  a_ack_in_stb: assert property (@(posedge clk) disable iff (reset_i)
    host.ack |-> host.stb);

endmodule

//--- verilog/system_ctrl.sv
// System control slave with version words, DAC control, volume register and PWM
`timescale 1ns/10ps
`include "creator_cfg.svh"

module system_ctrl import creator_bus_pkg::*, creator_regs_pkg::*; (
  input  logic clk,
  input  logic reset_i,
  wb_if.slave  bus,
  output logic dac_mute_o,
  output logic dac_hp_nspk_o,
  output logic dac_volume_o
);

  localparam logic [63:0] VERSION = `CREATOR_VERSION;
  localparam int VOL_W = `CREATOR_VOLUME_W;
  // Last count of the PWM period
  localparam logic [VOL_W-1:0] PWM_LAST = VOL_W'(`CREATOR_PWM_PERIOD - 1);

  ctrl_reg_e ofs;
  bus_data_t rd_data;
  bus_data_t volume_q;
  logic req;
  logic wr_en;
  logic [VOL_W-1:0] pwm_cnt;

  // Higher offset bits ignored
  assign ofs   = ctrl_reg_e'(bus.adr[$bits(ctrl_reg_e)-1:0]);
  assign req   = bus.cyc && bus.stb && !bus.ack;
  // Register update in the ack cycle
  assign wr_en = bus.cyc && bus.stb && bus.we && bus.ack;

  // --------------------
  // Read mux
  // --------------------
  always_comb begin
    case (ofs)
      VER0:     rd_data = VERSION[15:0];
      VER1:     rd_data = VERSION[31:16];
      VER2:     rd_data = VERSION[47:32];
      VER3:     rd_data = VERSION[63:48];
      DAC_CTRL: rd_data = bus_data_t'({dac_hp_nspk_o, dac_mute_o});
      VOLUME:   rd_data = volume_q;
      default:  rd_data = '0;
    endcase
  end

  // Ack one clock after the request, data alongside
  always_ff @(posedge clk) begin
    if (reset_i) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      bus.dat_r <= rd_data;
    end
  end

  // Writable registers, version words read only
  always_ff @(posedge clk) begin
    if (reset_i) begin
      dac_mute_o    <= `CREATOR_DAC_MUTE_INIT;
      dac_hp_nspk_o <= `CREATOR_DAC_HP_NSPK_INIT;
      volume_q      <= bus_data_t'(`CREATOR_VOLUME_INIT);
    end else if (wr_en) begin
      case (ofs)
        DAC_CTRL: begin
          dac_mute_o    <= bus.dat_w[DAC_MUTE_BIT];
          dac_hp_nspk_o <= bus.dat_w[DAC_HP_NSPK_BIT];
        end
        VOLUME:   volume_q <= bus.dat_w;
        default:  ;
      endcase
    end
  end

  // --------------------
  // Volume PWM
  // --------------------
  // Free running period, high while count below duty
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pwm_cnt      <= '0;
      dac_volume_o <= 1'b0;
    end else begin
      pwm_cnt      <= (pwm_cnt == PWM_LAST) ? '0 : pwm_cnt + 1'b1;
      dac_volume_o <= (pwm_cnt < volume_q[VOL_W-1:0]);
    end
  end

  // Single cycle ack even while the master still holds cyc
  a_ack_pulse: assert property (@(posedge clk) disable iff (reset_i)
    bus.ack |=> !bus.ack);

endmodule

//--- verilog/gpio_port.sv
// GPIO slave with direction, output and synchronized input registers
`timescale 1ns/10ps
`include "creator_cfg.svh"

module gpio_port import creator_bus_pkg::*, creator_regs_pkg::*; (
  input  logic                       clk,
  input  logic                       reset_i,
  wb_if.slave                        bus,
  input  logic [`CREATOR_GPIO_W-1:0] gpio_in_i,
  output logic [`CREATOR_GPIO_W-1:0] gpio_dir_o,
  output logic [`CREATOR_GPIO_W-1:0] gpio_out_o
);

  localparam int GPIO_W = `CREATOR_GPIO_W;

  gpio_reg_e ofs;
  bus_data_t rd_data;
  logic req;
  logic wr_en;
  logic [GPIO_W-1:0] in_meta;
  logic [GPIO_W-1:0] in_sync;

  assign ofs   = gpio_reg_e'(bus.adr[$bits(gpio_reg_e)-1:0]);
  assign req   = bus.cyc && bus.stb && !bus.ack;
  assign wr_en = bus.cyc && bus.stb && bus.we && bus.ack;

  // Two flop input synchronizer
  always_ff @(posedge clk) begin
    in_meta <= gpio_in_i;
    in_sync <= in_meta;
  end

  always_comb begin
    case (ofs)
      DIR:     rd_data = bus_data_t'(gpio_dir_o);
      OUT:     rd_data = bus_data_t'(gpio_out_o);
      IN:      rd_data = bus_data_t'(in_sync);
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      bus.dat_r <= rd_data;
    end
  end

  // IN is read only, so only DIR and OUT take writes
  always_ff @(posedge clk) begin
    if (reset_i) begin
      gpio_dir_o <= '0;
      gpio_out_o <= '0;
    end else if (wr_en) begin
      case (ofs)
        DIR:     gpio_dir_o <= GPIO_W'(bus.dat_w);
        OUT:     gpio_out_o <= GPIO_W'(bus.dat_w);
        default: ;
      endcase
    end
  end

  // Pin direction moves only after a completed write
  a_dir_after_write: assert property (@(posedge clk) disable iff (reset_i)
    $changed(gpio_dir_o) |-> $past(bus.ack && bus.we));

endmodule

//--- verilog/creator_core.sv
// Register system top level with SPI bridge, decoder, control and GPIO slaves
`timescale 1ns/10ps
`include "creator_cfg.svh"

module creator_core (
  input  logic                       clk,
  input  logic                       reset_i,
  // SPI host port
  input  logic                       spi_sck_i,
  input  logic                       spi_ss_i,
  input  logic                       spi_mosi_i,
  output logic                       spi_miso_o,
  // DAC control pins
  output logic                       dac_mute_o,
  output logic                       dac_hp_nspk_o,
  output logic                       dac_volume_o,
  // GPIO pins, split by direction
  input  logic [`CREATOR_GPIO_W-1:0] gpio_in_i,
  output logic [`CREATOR_GPIO_W-1:0] gpio_dir_o,
  output logic [`CREATOR_GPIO_W-1:0] gpio_out_o
);

  // --------------------
  // Bus segments
  // --------------------
  wb_if host_bus ();
  wb_if ctrl_bus ();
  wb_if gpio_bus ();

  // SPI host is the only master
  spi_wb_bridge spi0 (
    .clk     (clk),
    .reset_i (reset_i),
    .sck_i   (spi_sck_i),
    .ss_i    (spi_ss_i),
    .mosi_i  (spi_mosi_i),
    .miso_o  (spi_miso_o),
    .bus     (host_bus.master)
  );

  wb_decoder dec0 (
    .clk     (clk),
    .reset_i (reset_i),
    .host    (host_bus.slave),
    .ctrl    (ctrl_bus.master),
    .gpio    (gpio_bus.master)
  );

  // Region 000
  system_ctrl sysctl0 (
    .clk           (clk),
    .reset_i       (reset_i),
    .bus           (ctrl_bus.slave),
    .dac_mute_o    (dac_mute_o),
    .dac_hp_nspk_o (dac_hp_nspk_o),
    .dac_volume_o  (dac_volume_o)
  );

  // Region 100
  gpio_port gpio0 (
    .clk        (clk),
    .reset_i    (reset_i),
    .bus        (gpio_bus.slave),
    .gpio_in_i  (gpio_in_i),
    .gpio_dir_o (gpio_dir_o),
    .gpio_out_o (gpio_out_o)
  );

endmodule

//--- verif/creator_tb_spi.svh
// SPI mode 0 frame driver with write, read and cut frame tasks
`ifndef CREATOR_TB_SPI_SVH
`define CREATOR_TB_SPI_SVH

// --------------------
// Frame timing
// --------------------
// Clocks per sck half period
localparam int SPI_HALF = 8;
// Command word plus data word
localparam int SPI_BITS = 32;

// Drives nbits of {cmd, wdata} MSB first
// MISO collected over the data half only
// Called on a falling clock edge, returns on one
task automatic spi_frame(input bus_data_t cmd, input bus_data_t wdata, input int nbits,
                         output bus_data_t rdata);
  logic [SPI_BITS-1:0] frame;
  int i;
  frame  = {cmd, wdata};
  rdata  = 16'h0000;
  spi_ss = 1'b0;
  for (i = 0; i < nbits; i++) begin
    // MOSI moves while sck is low
    spi_mosi = frame[SPI_BITS-1-i];
    repeat (SPI_HALF) @(negedge clk);
    // Settled since the previous falling sck
    if (i >= SPI_BITS / 2) begin
      rdata = {rdata[14:0], spi_miso};
    end
    spi_sck = 1'b1;
    repeat (SPI_HALF) @(negedge clk);
    spi_sck = 1'b0;
  end
  // Select held past the last falling sck
  repeat (SPI_HALF) @(negedge clk);
  spi_ss   = 1'b1;
  spi_mosi = 1'b0;
  // Idle gap so the bit counter clears
  repeat (SPI_HALF) @(negedge clk);
endtask

task automatic spi_write(input bus_addr_t addr, input bus_data_t data);
  bus_data_t miso_word;
  spi_frame({1'b1, addr}, data, SPI_BITS, miso_word);
endtask

task automatic spi_read(input bus_addr_t addr, output bus_data_t data);
  spi_frame({1'b0, addr}, 16'h0000, SPI_BITS, data);
endtask

// Write command, deselected before its last data bit
task automatic spi_cut_write(input bus_addr_t addr, input bus_data_t data, input int nbits);
  bus_data_t miso_word;
  spi_frame({1'b1, addr}, data, nbits, miso_word);
endtask

`endif

//--- verif/creator_core_tb.sv
// Testbench for the register system with clock, reset, LCG, register model and checks
`timescale 1ns/10ps
`include "creator_cfg.svh"

module creator_core_tb import creator_bus_pkg::*; ();

  localparam int HALF_CLK     = 5;
  localparam int RESET_CYCLES = 16;
  localparam int N_VOL        = 8;
  localparam int N_DAC        = 8;
  localparam int N_GPIO       = 40;
  localparam int N_CUT        = 6;
  // Frames issued by the sequence below
  localparam int N_FRAMES     = 4 + 2 * N_VOL + 2 * N_DAC + 8 + 2 * N_GPIO + 8 + 12 + 2 * N_CUT;
  localparam int CYCLE_LIMIT  = N_FRAMES * 600 + 2000;
  localparam logic [63:0] VERSION = `CREATOR_VERSION;

  logic clk;
  logic reset_i;
  logic spi_sck;
  logic spi_ss;
  logic spi_mosi;
  logic spi_miso;
  logic dac_mute;
  logic dac_hp_nspk;
  logic dac_volume;
  logic [`CREATOR_GPIO_W-1:0] gpio_in;
  logic [`CREATOR_GPIO_W-1:0] gpio_dir;
  logic [`CREATOR_GPIO_W-1:0] gpio_out;

  // Register model
  logic      m_mute;
  logic      m_hp;
  bus_data_t m_volume;
  bus_data_t m_dir;
  bus_data_t m_out;

  logic [31:0] rng_state;
  int cycle_cnt;

  `include "creator_tb_spi.svh"

  creator_core dut0 (
    .clk           (clk),
    .reset_i       (reset_i),
    .spi_sck_i     (spi_sck),
    .spi_ss_i      (spi_ss),
    .spi_mosi_i    (spi_mosi),
    .spi_miso_o    (spi_miso),
    .dac_mute_o    (dac_mute),
    .dac_hp_nspk_o (dac_hp_nspk),
    .dac_volume_o  (dac_volume),
    .gpio_in_i     (gpio_in),
    .gpio_dir_o    (gpio_dir),
    .gpio_out_o    (gpio_out)
  );

  always #HALF_CLK clk = ~clk;

  // Watchdog sized from the frame count
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: test sequence still running after %0d clock cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  // --------------------
  // Helpers
  // --------------------
  // LCG, upper half returned since low bits cycle fast
  function logic [15:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected 0x%0h actual 0x%0h",
               $time, name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // Random bits between region and offset, ignored by the slaves
  function automatic bus_addr_t ctrl_addr(logic [3:0] ofs);
    logic [15:0] mid;
    mid = next_rand();
    return {`CREATOR_REGION_CTRL, mid[7:0], ofs};
  endfunction

  function automatic bus_addr_t gpio_addr(logic [1:0] ofs);
    logic [15:0] mid;
    mid = next_rand();
    return {`CREATOR_REGION_GPIO, mid[9:0], ofs};
  endfunction

  // Writable registers only; version words and IN ignore writes
  function automatic void model_write(bus_addr_t addr, bus_data_t data);
    if (addr[14:12] == `CREATOR_REGION_CTRL) begin
      if (addr[3:0] == 4'd4) begin
        m_mute = data[0];
        m_hp   = data[1];
      end else if (addr[3:0] == 4'd5) begin
        m_volume = data;
      end
    end else if (addr[14:12] == `CREATOR_REGION_GPIO) begin
      if (addr[1:0] == 2'd0) begin
        m_dir = data;
      end else if (addr[1:0] == 2'd1) begin
        m_out = data;
      end
    end
  endfunction

  // Expected read word, zero for anything unmapped
  function automatic bus_data_t model_read(bus_addr_t addr);
    bus_data_t value;
    value = 16'h0000;
    if (addr[14:12] == `CREATOR_REGION_CTRL) begin
      if (addr[3:2] == 2'b00) begin
        value = VERSION[int'(addr[1:0]) * 16 +: 16];
      end else if (addr[3:0] == 4'd4) begin
        value = {14'd0, m_hp, m_mute};
      end else if (addr[3:0] == 4'd5) begin
        value = m_volume;
      end
    end else if (addr[14:12] == `CREATOR_REGION_GPIO) begin
      if (addr[1:0] == 2'd0) begin
        value = m_dir;
      end else if (addr[1:0] == 2'd1) begin
        value = m_out;
      end else if (addr[1:0] == 2'd2) begin
        value = gpio_in;
      end
    end
    return value;
  endfunction

  task automatic check_outputs();
    check_value("dac_mute_o", m_mute, dac_mute);
    check_value("dac_hp_nspk_o", m_hp, dac_hp_nspk);
    check_value("gpio_dir_o", m_dir, gpio_dir);
    check_value("gpio_out_o", m_out, gpio_out);
  endtask

  // Any 30 consecutive clocks hold min(duty, 30) high cycles
  task automatic check_volume_pwm();
    int high;
    int expected;
    high = 0;
    repeat (`CREATOR_PWM_PERIOD) begin
      @(negedge clk);
      if (dac_volume) begin
        high++;
      end
    end
    expected = (m_volume[4:0] < `CREATOR_PWM_PERIOD) ? m_volume[4:0] : `CREATOR_PWM_PERIOD;
    check_value("dac_volume_o high cycles", expected, high);
  endtask

  task automatic write_reg(input bus_addr_t addr, input bus_data_t data);
    spi_write(addr, data);
    model_write(addr, data);
    repeat (6) @(negedge clk);
    check_outputs();
  endtask

  task automatic read_reg(input bus_addr_t addr, input string name);
    bus_data_t data;
    spi_read(addr, data);
    check_value(name, model_read(addr), data);
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    int i;
    int nbits;
    bus_data_t data;
    bus_addr_t addr;
    clk       = 1'b0;
    reset_i   = 1'b1;
    spi_sck   = 1'b0;
    spi_ss    = 1'b1;
    spi_mosi  = 1'b0;
    gpio_in   = '0;
    cycle_cnt = 0;
    rng_state = 32'h49017f0d;
    m_mute    = 1'b1;
    m_hp      = 1'b0;
    m_volume  = `CREATOR_VOLUME_INIT;
    m_dir     = '0;
    m_out     = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset_i = 1'b0;
    repeat (4) @(negedge clk);

    // Reset values and version words
    check_outputs();
    for (i = 0; i < 4; i++) begin
      read_reg(ctrl_addr(4'(i)), "VER read");
    end

    // Volume register and PWM duty
    check_volume_pwm();
    for (i = 0; i < N_VOL; i++) begin
      write_reg(ctrl_addr(4'd5), next_rand());
      check_volume_pwm();
      read_reg(ctrl_addr(4'd5), "VOLUME read");
    end

    // DAC control pins
    for (i = 0; i < N_DAC; i++) begin
      write_reg(ctrl_addr(4'd4), next_rand());
      read_reg(ctrl_addr(4'd4), "DAC_CTRL read");
    end
    // Version words are read only
    for (i = 0; i < 4; i++) begin
      write_reg(ctrl_addr(4'(i)), next_rand());
      read_reg(ctrl_addr(4'(i)), "VER read after write");
    end

    // GPIO DIR and OUT
    for (i = 0; i < N_GPIO; i++) begin
      data = next_rand();
      write_reg(gpio_addr({1'b0, data[15]}), next_rand());
      data = next_rand();
      read_reg(gpio_addr({1'b0, data[15]}), "GPIO DIR/OUT read");
    end

    // Synchronized inputs, held for the whole frame
    for (i = 0; i < 4; i++) begin
      gpio_in = next_rand();
      read_reg(gpio_addr(2'd2), "IN read");
    end
    write_reg(gpio_addr(2'd2), next_rand());
    read_reg(gpio_addr(2'd2), "IN read after write");
    read_reg(gpio_addr(2'd0), "DIR read after IN write");
    read_reg(gpio_addr(2'd1), "OUT read after IN write");

    // Unmapped regions
    for (i = 0; i < 8; i++) begin
      if (3'(i) != `CREATOR_REGION_CTRL && 3'(i) != `CREATOR_REGION_GPIO) begin
        data = next_rand();
        addr = {3'(i), data[11:0]};
        write_reg(addr, next_rand());
        read_reg(addr, "unmapped read");
      end
    end

    // Cut frames cause no access
    for (i = 0; i < N_CUT; i++) begin
      data  = next_rand();
      addr  = data[15] ? gpio_addr({1'b0, data[0]}) : ctrl_addr({3'b010, data[0]});
      nbits = int'(next_rand() % 31) + 1;
      spi_cut_write(addr, next_rand(), nbits);
      check_outputs();
      read_reg(addr, "read after cut frame");
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- creator_core.f
+incdir+verilog
+incdir+verif
verilog/creator_bus_pkg.sv
verilog/creator_regs_pkg.sv
verilog/wb_if.sv
verilog/spi_wb_bridge.sv
verilog/wb_decoder.sv
verilog/system_ctrl.sv
verilog/gpio_port.sv
verilog/creator_core.sv
verif/creator_core_tb.sv

//--- Bender.yml
package:
  name: creator_core

sources:
  # RTL, packages first
  - include_dirs:
      - verilog
    files:
      - verilog/creator_bus_pkg.sv
      - verilog/creator_regs_pkg.sv
      - verilog/wb_if.sv
      - verilog/spi_wb_bridge.sv
      - verilog/wb_decoder.sv
      - verilog/system_ctrl.sv
      - verilog/gpio_port.sv
      - verilog/creator_core.sv
  # Testbench
  - target: simulation
    include_dirs:
      - verilog
      - verif
    files:
      - verif/creator_core_tb.sv
